//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int TAG_W       = 4;
    localparam int NUM_ENTRIES = 2 ** TAG_W;    // tag 0 is never allocated
    localparam int XLEN        = 32;

    typedef enum logic [2:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW
    } mem_op_t;

    // one new entry from dispatch, written at index tag
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        mem_op_t          op;
        logic [XLEN-1:0]  imm;        // sign-extended
        logic [TAG_W-1:0] rs1_tag;    // 0 when rs1_val holds the value
        logic [XLEN-1:0]  rs1_val;
        logic [TAG_W-1:0] rs2_tag;
        logic [XLEN-1:0]  rs2_val;
    } dispatch_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } commit_t;

    typedef struct packed {
        logic             valid;
        mem_op_t          op;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  wdata;    // stores only
    } mem_req_t;

    // same memory word, whole or split into lanes
    typedef union packed {
        logic [XLEN-1:0]  word;
        logic [1:0][15:0] half;
        logic [3:0][7:0]  lane;
    } mem_word_u;

endpackage

`default_nettype wire

//--- hw/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire lsu_pkg::mem_req_t mem_req,
    output lsu_pkg::cdb_t          mem_rsp
);

    localparam int XLEN = lsu_pkg::XLEN;
    localparam int AW   = $clog2(MEM_WORDS);

    lsu_pkg::mem_word_u mem [MEM_WORDS];

    logic [AW-1:0]      word_idx;
    logic [1:0]         lane;
    logic               is_load;
    lsu_pkg::mem_word_u rd_word;
    logic [XLEN-1:0]    load_val;

    assign word_idx = mem_req.addr[AW+1:2];    // upper address bits wrap
    assign lane     = mem_req.addr[1:0];
    assign is_load  = !(mem_req.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW});
    assign rd_word  = mem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_req.valid) begin
            case (mem_req.op)
                lsu_pkg::SB: mem[word_idx].lane[lane]    <= mem_req.wdata[7:0];
                lsu_pkg::SH: mem[word_idx].half[lane[1]] <= mem_req.wdata[15:0];
                lsu_pkg::SW: mem[word_idx].word          <= mem_req.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (mem_req.op)
            lsu_pkg::LB: begin
                load_val = {{24{rd_word.lane[lane][7]}}, rd_word.lane[lane]};
            end
            lsu_pkg::LBU: begin
                load_val = {24'b0, rd_word.lane[lane]};
            end
            lsu_pkg::LH: begin
                load_val = {{16{rd_word.half[lane[1]][15]}}, rd_word.half[lane[1]]};
            end
            lsu_pkg::LHU: begin
                load_val = {16'b0, rd_word.half[lane[1]]};
            end
            default: begin
                load_val = rd_word.word;    // LW, half/word alignment assumed
            end
        endcase
    end

    // only loads answer
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rsp.valid <= 1'b0;
        end else begin
            mem_rsp.valid <= mem_req.valid && is_load;
            mem_rsp.tag   <= mem_req.tag;
            mem_rsp.data  <= load_val;
        end
    end

endmodule

`default_nettype wire

//--- hw/ls_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module ls_buffer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire lsu_pkg::dispatch_t dispatch,
    input  wire lsu_pkg::cdb_t      exec_cdb,
    input  wire lsu_pkg::commit_t   commit,
    input  wire lsu_pkg::cdb_t      mem_rsp,
    output lsu_pkg::mem_req_t       mem_req,
    output lsu_pkg::cdb_t           result
);

    localparam int TAG_W       = lsu_pkg::TAG_W;
    localparam int NUM_ENTRIES = lsu_pkg::NUM_ENTRIES;
    localparam int XLEN        = lsu_pkg::XLEN;

    logic [NUM_ENTRIES-1:0] occupied;
    logic [NUM_ENTRIES-1:0] issued;      // load already sent to memory
    logic [NUM_ENTRIES-1:0] is_store;
    logic [NUM_ENTRIES-1:0] rs1_rdy;
    logic [NUM_ENTRIES-1:0] rs2_rdy;

    lsu_pkg::mem_op_t op      [NUM_ENTRIES];
    logic [XLEN-1:0]  imm     [NUM_ENTRIES];
    logic [TAG_W-1:0] rs1_tag [NUM_ENTRIES];
    logic [XLEN-1:0]  rs1_val [NUM_ENTRIES];
    logic [TAG_W-1:0] rs2_tag [NUM_ENTRIES];
    logic [XLEN-1:0]  rs2_val [NUM_ENTRIES];

    logic [NUM_ENTRIES-1:0] eligible;
    logic                   load_found;
    logic [TAG_W-1:0]       load_sel;
    logic [XLEN-1:0]        store_addr;
    logic [XLEN-1:0]        load_addr;

    // pending tag seen on either result bus this cycle
    function automatic logic snoop_hit(input logic [TAG_W-1:0] tag);
        return tag != '0 &&
               ((exec_cdb.valid && exec_cdb.tag == tag) ||
                (result.valid && result.tag == tag));
    endfunction

    function automatic logic [XLEN-1:0] snoop_val(input logic [TAG_W-1:0] tag,
                                                  input logic [XLEN-1:0]  held);
        if (tag != '0 && exec_cdb.valid && exec_cdb.tag == tag) begin
            return exec_cdb.data;
        end
        if (tag != '0 && result.valid && result.tag == tag) begin
            return result.data;
        end
        return held;
    endfunction

    assign eligible   = occupied & rs1_rdy & ~issued & ~is_store;
    assign load_found = |eligible;

    // lowest tag wins
    always_comb begin
        load_sel = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                load_sel = TAG_W'(i);
            end
        end
    end

    assign store_addr = rs1_val[commit.tag] + imm[commit.tag];
    assign load_addr  = rs1_val[load_sel] + imm[load_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
            issued   <= '0;
        end else begin
            if (commit.valid) begin
                occupied[commit.tag] <= 1'b0;    // store leaves at commit
            end else if (load_found) begin
                issued[load_sel] <= 1'b1;
            end
            if (mem_rsp.valid) begin
                occupied[mem_rsp.tag] <= 1'b0;
                issued[mem_rsp.tag]   <= 1'b0;
            end
            if (dispatch.valid) begin
                occupied[dispatch.tag] <= 1'b1;
                issued[dispatch.tag]   <= 1'b0;
            end
        end
    end

    // operand wakeup, then new entries
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (occupied[i] && !rs1_rdy[i] && snoop_hit(rs1_tag[i])) begin
                rs1_rdy[i] <= 1'b1;
                rs1_val[i] <= snoop_val(rs1_tag[i], rs1_val[i]);
            end
            if (occupied[i] && !rs2_rdy[i] && snoop_hit(rs2_tag[i])) begin
                rs2_rdy[i] <= 1'b1;
                rs2_val[i] <= snoop_val(rs2_tag[i], rs2_val[i]);
            end
        end
        if (dispatch.valid) begin
            is_store[dispatch.tag] <= dispatch.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
            op[dispatch.tag]       <= dispatch.op;
            imm[dispatch.tag]      <= dispatch.imm;
            rs1_tag[dispatch.tag]  <= dispatch.rs1_tag;
            rs2_tag[dispatch.tag]  <= dispatch.rs2_tag;
            // catch a broadcast landing in the dispatch cycle
            rs1_rdy[dispatch.tag]  <= dispatch.rs1_tag == '0 || snoop_hit(dispatch.rs1_tag);
            rs2_rdy[dispatch.tag]  <= dispatch.rs2_tag == '0 || snoop_hit(dispatch.rs2_tag);
            rs1_val[dispatch.tag]  <= snoop_val(dispatch.rs1_tag, dispatch.rs1_val);
            rs2_val[dispatch.tag]  <= snoop_val(dispatch.rs2_tag, dispatch.rs2_val);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req.valid <= 1'b0;
        end else if (commit.valid) begin
            mem_req.valid <= 1'b1;
            mem_req.op    <= op[commit.tag];
            mem_req.tag   <= commit.tag;
            mem_req.addr  <= store_addr;
            mem_req.wdata <= rs2_val[commit.tag];
        end else if (load_found) begin
            mem_req.valid <= 1'b1;
            mem_req.op    <= op[load_sel];
            mem_req.tag   <= load_sel;
            mem_req.addr  <= load_addr;
            mem_req.wdata <= '0;
        end else begin
            mem_req.valid <= 1'b0;
        end
    end

    // load broadcast, also fed back to wakeup
    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result <= mem_rsp;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire lsu_pkg::dispatch_t dispatch,
    input  wire lsu_pkg::cdb_t      exec_cdb,
    input  wire lsu_pkg::commit_t   commit,
    output lsu_pkg::cdb_t           result
);

    lsu_pkg::mem_req_t mem_req;
    lsu_pkg::cdb_t     mem_rsp;

    ls_buffer u_ls_buffer (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .exec_cdb (exec_cdb),
        .commit   (commit),
        .mem_rsp  (mem_rsp),
        .mem_req  (mem_req),
        .result   (result)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

`default_nettype wire

//--- tb/lsu_properties.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_properties (
    input wire                               clk,
    input wire                               rst,
    input wire lsu_pkg::commit_t             commit,
    input wire lsu_pkg::mem_req_t            mem_req,
    input wire lsu_pkg::cdb_t                result,
    input wire [lsu_pkg::NUM_ENTRIES-1:0]    occupied,
    input wire [lsu_pkg::NUM_ENTRIES-1:0]    is_store,
    input wire [lsu_pkg::NUM_ENTRIES-1:0]    rs1_rdy,
    input wire [lsu_pkg::NUM_ENTRIES-1:0]    rs2_rdy
);

    logic commit_ok;

    assign commit_ok = occupied[commit.tag] && is_store[commit.tag] &&
                       rs1_rdy[commit.tag] && rs2_rdy[commit.tag];

    result_tag_nonzero: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> result.tag != '0)
        else $error("load result broadcast with tag 0");

    commit_names_ready_store: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit_ok)
        else $error("commit of a free, non-store or unready entry");

    // both strobes clear right after reset
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!mem_req.valid && !result.valid))
        else $error("strobe active in the cycle after reset");

endmodule

bind ls_buffer lsu_properties u_properties (
    .clk      (clk),
    .rst      (rst),
    .commit   (commit),
    .mem_req  (mem_req),
    .result   (result),
    .occupied (occupied),
    .is_store (is_store),
    .rs1_rdy  (rs1_rdy),
    .rs2_rdy  (rs2_rdy)
);

`default_nettype wire

//--- tb/tb_lsu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

    localparam int TAG_W          = lsu_pkg::TAG_W;
    localparam int RESULT_TIMEOUT = 60;    // cycles

    logic               clk;
    logic               rst;
    lsu_pkg::dispatch_t dispatch;
    lsu_pkg::cdb_t      exec_cdb;
    lsu_pkg::commit_t   commit;
    lsu_pkg::cdb_t      result;

    logic [31:0]        lfsr_state;
    logic [7:0]         model_mem [0:1023];    // byte image of the 256-word memory
    lsu_pkg::cdb_t      result_q [$];

    lsu_top #(
        .MEM_WORDS (256)
    ) dut (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .exec_cdb (exec_cdb),
        .commit   (commit),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // broadcasts taken at the rising edge, before they update
    always @(posedge clk) begin
        if (!rst && result.valid) begin
            result_q.push_back(result);
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_imm();
        logic [31:0] r;
        r = rand_bits(12);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // little endian, lane 0 is the low byte
    function automatic logic [31:0] expected_load(input lsu_pkg::mem_op_t op,
                                                  input logic [31:0] addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[9:0];
        b = model_mem[a];
        h = {model_mem[{a[9:1], 1'b1}], model_mem[{a[9:1], 1'b0}]};
        case (op)
            lsu_pkg::LB:  return {{24{b[7]}}, b};
            lsu_pkg::LBU: return {24'h0, b};
            lsu_pkg::LH:  return {{16{h[15]}}, h};
            lsu_pkg::LHU: return {16'h0, h};
            default: return {model_mem[{a[9:2], 2'd3}], model_mem[{a[9:2], 2'd2}],
                             model_mem[{a[9:2], 2'd1}], model_mem[{a[9:2], 2'd0}]};
        endcase
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic dispatch_entry(input logic [TAG_W-1:0] tag, input lsu_pkg::mem_op_t op,
                                  input logic [31:0] imm, input logic [TAG_W-1:0] rs1_tag,
                                  input logic [31:0] rs1_val, input logic [31:0] rs2_val);
        dispatch.valid   = 1'b1;
        dispatch.tag     = tag;
        dispatch.op      = op;
        dispatch.imm     = imm;
        dispatch.rs1_tag = rs1_tag;
        dispatch.rs1_val = rs1_val;
        dispatch.rs2_tag = '0;
        dispatch.rs2_val = rs2_val;
        @(negedge clk);
        dispatch = '0;
    endtask

    task automatic store_op(input logic [TAG_W-1:0] tag, input lsu_pkg::mem_op_t op,
                            input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] imm;
        logic [9:0]  a;
        imm = rand_imm();
        a = addr[9:0];
        dispatch_entry(tag, op, imm, '0, addr - imm, data);
        commit.valid = 1'b1;
        commit.tag   = tag;
        @(negedge clk);
        commit = '0;
        case (op)
            lsu_pkg::SB: model_mem[a] = data[7:0];
            lsu_pkg::SH: begin
                model_mem[{a[9:1], 1'b0}] = data[7:0];
                model_mem[{a[9:1], 1'b1}] = data[15:8];
            end
            default: begin
                model_mem[{a[9:2], 2'd0}] = data[7:0];
                model_mem[{a[9:2], 2'd1}] = data[15:8];
                model_mem[{a[9:2], 2'd2}] = data[23:16];
                model_mem[{a[9:2], 2'd3}] = data[31:24];
            end
        endcase
    endtask

    task automatic wait_result(output logic [TAG_W-1:0] tag, output logic [31:0] data);
        lsu_pkg::cdb_t r;
        int cycles;
        cycles = 0;
        while (result_q.size() == 0) begin
            if (cycles == RESULT_TIMEOUT) begin
                $display("no load result within %0d cycles", RESULT_TIMEOUT);
                abort_run();
            end
            @(negedge clk);
            cycles++;
        end
        r = result_q.pop_front();
        tag = r.tag;
        data = r.data;
    endtask

    task automatic load_and_check(input logic [TAG_W-1:0] tag, input lsu_pkg::mem_op_t op,
                                  input logic [31:0] addr);
        logic [31:0]      imm;
        logic [TAG_W-1:0] got_tag;
        logic [31:0]      got_data;
        imm = rand_imm();
        dispatch_entry(tag, op, imm, '0, addr - imm, '0);
        wait_result(got_tag, got_data);
        check_value("result.tag", 32'(got_tag), 32'(tag));
        check_value("result.data", got_data, expected_load(op, addr));
    endtask

    task automatic idle_after_reset();
        repeat (8) begin
            check_value("result.valid", 32'(result.valid), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic word_round_trip();
        store_op(TAG_W'(1), lsu_pkg::SW, 32'h20, rand_bits(32));
        load_and_check(TAG_W'(2), lsu_pkg::LW, 32'h20);
    endtask

    task automatic subword_lanes();
        logic [31:0] data;
        for (int i = 0; i < 4; i++) begin
            data = rand_bits(8);
            if (i == 1) data[7] = 1'b1;    // one negative, one positive byte
            if (i == 2) data[7] = 1'b0;
            store_op(TAG_W'(i + 1), lsu_pkg::SB, 32'h80 + 32'(i), data);
        end
        data = rand_bits(16) | 32'h8000;
        store_op(TAG_W'(5), lsu_pkg::SH, 32'h84, data);
        data = rand_bits(16) & 32'h7fff;
        store_op(TAG_W'(6), lsu_pkg::SH, 32'h86, data);
        for (int i = 0; i < 4; i++) begin
            load_and_check(TAG_W'(7), lsu_pkg::LB, 32'h80 + 32'(i));
            load_and_check(TAG_W'(8), lsu_pkg::LBU, 32'h80 + 32'(i));
        end
        for (int i = 0; i < 2; i++) begin
            load_and_check(TAG_W'(9), lsu_pkg::LH, 32'h84 + 32'(2 * i));
            load_and_check(TAG_W'(10), lsu_pkg::LHU, 32'h84 + 32'(2 * i));
        end
        load_and_check(TAG_W'(11), lsu_pkg::LW, 32'h80);
    endtask

    task automatic pending_base_wakeup();
        logic [TAG_W-1:0] got_tag;
        logic [31:0]      got_data;
        store_op(TAG_W'(1), lsu_pkg::SW, 32'h150, rand_bits(32));
        // base comes from exec tag 12, held value is junk
        dispatch_entry(TAG_W'(3), lsu_pkg::LW, 32'h10, TAG_W'(12), 32'hdeadbeef, '0);
        repeat (6) begin
            check_value("result.valid", 32'(result.valid), 32'd0);
            check_value("result count", 32'(result_q.size()), 32'd0);
            @(negedge clk);
        end
        exec_cdb.valid = 1'b1;
        exec_cdb.tag   = TAG_W'(12);
        exec_cdb.data  = 32'h140;
        @(negedge clk);
        exec_cdb = '0;
        wait_result(got_tag, got_data);
        check_value("result.tag", 32'(got_tag), 32'd3);
        check_value("result.data", got_data, expected_load(lsu_pkg::LW, 32'h140 + 32'h10));
    endtask

    task automatic chained_load_wakeup();
        logic [31:0]      imm;
        logic [TAG_W-1:0] got_tag;
        logic [31:0]      got_data;
        store_op(TAG_W'(1), lsu_pkg::SW, 32'h40, 32'h300);    // pointer
        store_op(TAG_W'(2), lsu_pkg::SW, 32'h308, rand_bits(32));
        imm = rand_imm();
        dispatch_entry(TAG_W'(4), lsu_pkg::LW, imm, '0, 32'h40 - imm, '0);
        dispatch_entry(TAG_W'(5), lsu_pkg::LW, 32'h8, TAG_W'(4), '0, '0);
        wait_result(got_tag, got_data);
        check_value("result.tag", 32'(got_tag), 32'd4);
        check_value("result.data", got_data, expected_load(lsu_pkg::LW, 32'h40));
        wait_result(got_tag, got_data);
        check_value("result.tag", 32'(got_tag), 32'd5);
        check_value("result.data", got_data,
                    expected_load(lsu_pkg::LW, expected_load(lsu_pkg::LW, 32'h40) + 32'h8));
    endtask

    task automatic random_store_load_mix();
        logic [31:0]      addr [6];
        lsu_pkg::mem_op_t ops [6];
        logic [31:0]      exp_data [16];
        logic [15:0]      pending;
        logic [31:0]      sel;
        logic [31:0]      imm;
        logic [TAG_W-1:0] got_tag;
        logic [31:0]      got_data;
        pending = '0;
        for (int i = 0; i < 6; i++) begin
            store_op(TAG_W'(i + 1), lsu_pkg::SW, 32'h200 + 32'(4 * i), rand_bits(32));
        end
        for (int i = 0; i < 6; i++) begin
            sel = rand_bits(2);
            case (sel[1:0])
                2'd0: begin
                    ops[i] = lsu_pkg::LW;
                    addr[i] = 32'h200 + 32'(4 * i);
                end
                2'd1: begin
                    ops[i] = lsu_pkg::LH;
                    addr[i] = 32'h200 + 32'(4 * i) + (rand_bits(1) << 1);
                end
                2'd2: begin
                    ops[i] = lsu_pkg::LBU;
                    addr[i] = 32'h200 + 32'(4 * i) + rand_bits(2);
                end
                default: begin
                    ops[i] = lsu_pkg::LB;
                    addr[i] = 32'h200 + 32'(4 * i) + rand_bits(2);
                end
            endcase
            exp_data[i + 7] = expected_load(ops[i], addr[i]);
            pending[i + 7] = 1'b1;
        end
        for (int i = 0; i < 6; i++) begin
            imm = rand_imm();
            dispatch_entry(TAG_W'(i + 7), ops[i], imm, '0, addr[i] - imm, '0);
        end
        repeat (6) begin
            wait_result(got_tag, got_data);
            if (!pending[got_tag]) begin
                $display("load result with unexpected tag %0d", got_tag);
                abort_run();
            end
            check_value("result.data", got_data, exp_data[got_tag]);
            pending[got_tag] = 1'b0;
        end
    endtask

    initial begin
        lfsr_state = 32'hba9ff4a4;
        rst        = 1'b1;
        dispatch   = '0;
        exec_cdb   = '0;
        commit     = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        idle_after_reset();
        word_round_trip();
        subword_lanes();
        pending_base_wakeup();
        chained_load_wakeup();
        random_store_load_mix();
        repeat (4) @(negedge clk);
        check_value("leftover results", 32'(result_q.size()), 32'd0);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hw/lsu_pkg.sv
hw/data_mem.sv
hw/ls_buffer.sv
hw/lsu_top.sv
tb/lsu_properties.sv
tb/tb_lsu.sv

//--- Makefile
SRCS := $(shell cat project.f)

.PHONY: run clean

run: obj_dir/Vtb_lsu
	./obj_dir/Vtb_lsu > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

obj_dir/Vtb_lsu: project.f $(SRCS)
	verilator --binary --assert --top-module tb_lsu -Mdir obj_dir -f project.f

clean:
	rm -rf obj_dir sim.log
